// ==== design/endpoint_pkg.sv ====
package endpoint_pkg;

    ////////////////////////////////////////
    // data types
    ////////////////////////////////////////

    typedef logic [31:0] word_t;

    // one flit carries a full word plus the end of message marker.
    typedef struct packed {
        word_t data;
        logic  last;
    } flit_t;

    ////////////////////////////////////////
    // host address map
    ////////////////////////////////////////

    // slot i of the start table sits at START_TABLE_BASE + 4*i.
    localparam word_t START_TABLE_BASE = 32'h0000_0000;
    localparam word_t TX_SEND_ADDR     = 32'h0000_1004;
    localparam word_t RX_COUNT_ADDR    = 32'h0000_1008;
    localparam word_t TX_BUF_BASE      = 32'h0000_2000;
    localparam word_t RX_BUF_BASE      = 32'h0000_3000;

    // returned for reads that hit nothing.
    localparam word_t BAD_DATA = 32'hBAD1_BAD1;

    // payload length field in the low bits of a header word.
    localparam int HDR_LEN_BITS = 8;

endpackage

// ==== design/mem_bus_if.sv ====
`timescale 1ns/100ps

interface mem_bus_if #(
    parameter int NUM_WORDS = 128
);
    logic                         wen;
    logic                         ren;
    logic [$clog2(NUM_WORDS)-1:0] addr;
    endpoint_pkg::word_t          wdata;
    logic [3:0]                   strobe;
    endpoint_pkg::word_t          rdata;

    modport host (
        output wen, ren, addr, wdata, strobe,
        input  rdata
    );

    modport target (
        input  wen, ren, addr, wdata, strobe,
        output rdata
    );

endinterface

// ==== design/word_buffer.sv ====
`timescale 1ns/100ps

module word_buffer #(
    parameter int NUM_WORDS = 128
) (
    input logic       clk,
    input logic       n_rst,
    mem_bus_if.target bus
);

    endpoint_pkg::word_t mem [NUM_WORDS];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    // byte lanes are written only where the strobe is set.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (bus.wen) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.strobe[lane]) begin
                    mem[bus.addr][8*lane +: 8] <= bus.wdata[8*lane +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    // combinational read, quiet when nobody asks.
    always_comb begin
        if (bus.ren) begin
            bus.rdata = mem[bus.addr];
        end else begin
            bus.rdata = '0;
        end
    end

endmodule

// ==== design/tx_engine.sv ====
`timescale 1ns/100ps

module tx_engine #(
    parameter int NUM_WORDS = 128
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         send_start,
    input  logic [$clog2(NUM_WORDS)-1:0] send_addr,
    output logic                         tx_rd_en,
    output logic [$clog2(NUM_WORDS)-1:0] tx_rd_addr,
    input  endpoint_pkg::word_t          tx_rd_data,
    output logic                         busy,
    output endpoint_pkg::flit_t          flit_out,
    output logic                         flit_out_valid
);

    localparam int AW = $clog2(NUM_WORDS);
    localparam int LW = endpoint_pkg::HDR_LEN_BITS;

    typedef enum logic [1:0] {
        state_idle,
        state_header,
        state_stream
    } state_t;

    state_t        state;
    logic [AW-1:0] ptr;
    logic [LW-1:0] remaining;
    logic [LW-1:0] hdr_len;
    logic          last_next;

    assign hdr_len    = tx_rd_data[LW-1:0];
    assign tx_rd_en   = (state == state_header) || (state == state_stream);
    assign tx_rd_addr = ptr;

    // busy covers the cycle in which the final flit is still on the port.
    assign busy = (state != state_idle) || flit_out_valid;

    // a zero length header is its own last flit.
    assign last_next = (state == state_header) ? (hdr_len == '0) : (remaining == LW'(1));

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state          <= state_idle;
            ptr            <= '0;
            remaining      <= '0;
            flit_out_valid <= 1'b0;
        end else begin
            flit_out_valid <= tx_rd_en;
            case (state)
                state_idle: begin
                    if (send_start) begin
                        ptr   <= send_addr;
                        state <= state_header;
                    end
                end
                state_header: begin
                    remaining <= hdr_len;
                    ptr       <= ptr + AW'(1);
                    state     <= (hdr_len == '0) ? state_idle : state_stream;
                end
                state_stream: begin
                    remaining <= remaining - LW'(1);
                    ptr       <= ptr + AW'(1);
                    if (remaining == LW'(1)) begin
                        state <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // outgoing flit, loaded with each word read.
    always_ff @(posedge clk) begin
        if (tx_rd_en) begin
            flit_out.data <= tx_rd_data;
            flit_out.last <= last_next;
        end
    end

endmodule

// ==== design/rx_assembler.sv ====
`timescale 1ns/100ps

module rx_assembler #(
    parameter int NUM_WORDS = 128
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         data_ready,
    input  endpoint_pkg::flit_t          flit_in,
    output logic                         rx_wr_en,
    output logic [$clog2(NUM_WORDS)-1:0] rx_wr_addr,
    output endpoint_pkg::word_t          rx_wr_data,
    output logic [15:0]                  rx_count
);

    localparam int AW = $clog2(NUM_WORDS);

    logic [AW-1:0] wr_ptr;

    // every strobe becomes exactly one buffer write.
    assign rx_wr_en   = data_ready;
    assign rx_wr_addr = wr_ptr;
    assign rx_wr_data = flit_in.data;

    // pointer wraps at the buffer depth, the count keeps going.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr   <= '0;
            rx_count <= '0;
        end else if (data_ready) begin
            wr_ptr   <= wr_ptr + AW'(1);
            rx_count <= rx_count + 16'd1;
        end
    end

endmodule

// ==== design/endpoint_decoder.sv ====
`timescale 1ns/100ps

module endpoint_decoder #(
    parameter int NUM_MSGS  = 4,
    parameter int NUM_WORDS = 128
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         bus_wen,
    input  logic                         bus_ren,
    input  endpoint_pkg::word_t          bus_addr,
    input  endpoint_pkg::word_t          bus_wdata,
    input  logic [3:0]                   bus_strobe,
    output endpoint_pkg::word_t          bus_rdata,
    output logic                         bus_error,
    output logic                         bus_request_stall,
    mem_bus_if.host                      tx_buf_bus,
    mem_bus_if.host                      rx_buf_bus,
    input  logic                         tx_rd_en,
    input  logic [$clog2(NUM_WORDS)-1:0] tx_rd_addr,
    output endpoint_pkg::word_t          tx_rd_data,
    input  logic                         rx_wr_en,
    input  logic [$clog2(NUM_WORDS)-1:0] rx_wr_addr,
    input  endpoint_pkg::word_t          rx_wr_data,
    input  logic                         busy,
    input  logic [15:0]                  rx_count,
    output logic                         send_start,
    output logic [$clog2(NUM_WORDS)-1:0] send_addr
);

    localparam int AW = $clog2(NUM_WORDS);
    localparam int MW = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1;
    localparam endpoint_pkg::word_t TABLE_BYTES = endpoint_pkg::word_t'(NUM_MSGS * 4);
    localparam endpoint_pkg::word_t BUF_BYTES   = endpoint_pkg::word_t'(NUM_WORDS * 4);

    endpoint_pkg::word_t start_table [NUM_MSGS];
    logic                table_we;
    logic [MW-1:0]       table_idx;
    logic [MW-1:0]       send_slot;
    logic [AW-1:0]       buf_idx;
    logic                in_table;
    logic                in_tx_buf;
    logic                in_rx_buf;

    assign table_idx = bus_addr[2 +: MW];
    assign send_slot = bus_wdata[MW-1:0];
    assign buf_idx   = bus_addr[AW+1:2];

    assign in_table  = (bus_addr - endpoint_pkg::START_TABLE_BASE) < TABLE_BYTES;
    assign in_tx_buf = (bus_addr >= endpoint_pkg::TX_BUF_BASE) &&
                       (bus_addr <  endpoint_pkg::TX_BUF_BASE + BUF_BYTES);
    assign in_rx_buf = (bus_addr >= endpoint_pkg::RX_BUF_BASE) &&
                       (bus_addr <  endpoint_pkg::RX_BUF_BASE + BUF_BYTES);

    ////////////////////////////////////////
    // start table
    ////////////////////////////////////////

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_MSGS; i++) begin
                start_table[i] <= '0;
            end
        end else if (table_we) begin
            start_table[table_idx] <= bus_wdata & ~32'h3;
        end
    end

    ////////////////////////////////////////
    // decode and buffer arbitration
    ////////////////////////////////////////

    always_comb begin
        tx_buf_bus.wen    = 1'b0;
        tx_buf_bus.ren    = 1'b0;
        tx_buf_bus.addr   = '0;
        tx_buf_bus.wdata  = '0;
        tx_buf_bus.strobe = '0;
        rx_buf_bus.wen    = 1'b0;
        rx_buf_bus.ren    = 1'b0;
        rx_buf_bus.addr   = '0;
        rx_buf_bus.wdata  = '0;
        rx_buf_bus.strobe = '0;
        tx_rd_data        = tx_buf_bus.rdata;
        bus_rdata         = endpoint_pkg::BAD_DATA;
        bus_error         = 1'b0;
        bus_request_stall = 1'b0;
        send_start        = 1'b0;
        send_addr         = '0;
        table_we          = 1'b0;

        // engine ports take the buffers first.
        if (tx_rd_en) begin
            tx_buf_bus.ren  = 1'b1;
            tx_buf_bus.addr = tx_rd_addr;
        end
        if (rx_wr_en) begin
            rx_buf_bus.wen    = 1'b1;
            rx_buf_bus.addr   = rx_wr_addr;
            rx_buf_bus.wdata  = rx_wr_data;
            rx_buf_bus.strobe = 4'hF;
        end

        if (in_table) begin
            bus_rdata = start_table[table_idx];
            table_we  = bus_wen;
        end else if (bus_addr == endpoint_pkg::TX_SEND_ADDR) begin
            if (bus_wen) begin
                if (bus_wdata >= NUM_MSGS || busy) begin
                    bus_error = 1'b1;
                end else begin
                    send_start = 1'b1;
                    send_addr  = start_table[send_slot][AW+1:2];
                end
            end
        end else if (bus_addr == endpoint_pkg::RX_COUNT_ADDR) begin
            bus_rdata = {16'h0000, rx_count};
        end else if (in_tx_buf) begin
            if (busy) begin
                bus_request_stall = bus_wen || bus_ren;
            end else begin
                tx_buf_bus.wen    = bus_wen;
                tx_buf_bus.ren    = bus_ren;
                tx_buf_bus.addr   = buf_idx;
                tx_buf_bus.wdata  = bus_wdata;
                tx_buf_bus.strobe = bus_strobe;
                bus_rdata         = tx_buf_bus.rdata;
            end
        end else if (in_rx_buf) begin
            // receive buffer is read only from the host side.
            if (bus_wen) begin
                bus_error = 1'b1;
            end else if (rx_wr_en) begin
                bus_request_stall = bus_ren;
            end else begin
                rx_buf_bus.ren  = bus_ren;
                rx_buf_bus.addr = buf_idx;
                bus_rdata       = rx_buf_bus.rdata;
            end
        end
    end

endmodule

// ==== design/chiplet_endpoint.sv ====
`timescale 1ns/100ps

module chiplet_endpoint #(
    parameter int NUM_MSGS  = 4,
    parameter int NUM_WORDS = 128
) (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                data_ready,
    input  endpoint_pkg::flit_t flit_in,
    output endpoint_pkg::flit_t flit_out,
    output logic                flit_out_valid,
    input  logic                bus_wen,
    input  logic                bus_ren,
    input  endpoint_pkg::word_t bus_addr,
    input  endpoint_pkg::word_t bus_wdata,
    input  logic [3:0]          bus_strobe,
    output endpoint_pkg::word_t bus_rdata,
    output logic                bus_error,
    output logic                bus_request_stall
);

    localparam int AW = $clog2(NUM_WORDS);

    logic                tx_rd_en;
    logic [AW-1:0]       tx_rd_addr;
    endpoint_pkg::word_t tx_rd_data;
    logic                rx_wr_en;
    logic [AW-1:0]       rx_wr_addr;
    endpoint_pkg::word_t rx_wr_data;
    logic                busy;
    logic [15:0]         rx_count;
    logic                send_start;
    logic [AW-1:0]       send_addr;

    mem_bus_if #(.NUM_WORDS(NUM_WORDS)) tx_buf_bus ();
    mem_bus_if #(.NUM_WORDS(NUM_WORDS)) rx_buf_bus ();

    endpoint_decoder #(.NUM_MSGS(NUM_MSGS), .NUM_WORDS(NUM_WORDS)) decoder_i (
        .clk, .n_rst,
        .bus_wen, .bus_ren, .bus_addr, .bus_wdata, .bus_strobe,
        .bus_rdata, .bus_error, .bus_request_stall,
        .tx_buf_bus, .rx_buf_bus,
        .tx_rd_en, .tx_rd_addr, .tx_rd_data,
        .rx_wr_en, .rx_wr_addr, .rx_wr_data,
        .busy, .rx_count, .send_start, .send_addr
    );

    tx_engine #(.NUM_WORDS(NUM_WORDS)) tx_engine_i (
        .clk, .n_rst, .send_start, .send_addr,
        .tx_rd_en, .tx_rd_addr, .tx_rd_data,
        .busy, .flit_out, .flit_out_valid
    );

    rx_assembler #(.NUM_WORDS(NUM_WORDS)) rx_assembler_i (
        .clk, .n_rst, .data_ready, .flit_in,
        .rx_wr_en, .rx_wr_addr, .rx_wr_data, .rx_count
    );

    word_buffer #(.NUM_WORDS(NUM_WORDS)) tx_buf (.clk, .n_rst, .bus(tx_buf_bus));
    word_buffer #(.NUM_WORDS(NUM_WORDS)) rx_buf (.clk, .n_rst, .bus(rx_buf_bus));

endmodule

// ==== testbench/endpoint_tests.svh ====
////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic start_table_readback();
    word_t values [NUM_MSGS];
    word_t rdata;
    logic  err;
    int    stalls;
    for (int i = 0; i < NUM_MSGS; i++) begin
        values[i] = next_random();
        write_word(endpoint_pkg::START_TABLE_BASE + 32'(4 * i), values[i], 4'hF, err);
        check("bus_error", 32'(err), 32'h0);
    end
    for (int i = 0; i < NUM_MSGS; i++) begin
        read_word(endpoint_pkg::START_TABLE_BASE + 32'(4 * i), rdata, stalls);
        check("bus_rdata", rdata, values[i] & ~32'h3);
    end
    // slot numbers past the table are refused.
    write_word(endpoint_pkg::TX_SEND_ADDR, 32'(NUM_MSGS), 4'hF, err);
    check("bus_error", 32'(err), 32'h1);
    write_word(endpoint_pkg::TX_SEND_ADDR, 32'h0000_0100, 4'hF, err);
    check("bus_error", 32'(err), 32'h1);
endtask

task automatic tx_buffer_strobes();
    word_t      expected [TXBUF_WORDS];
    word_t      full;
    word_t      part;
    word_t      rdata;
    logic [3:0] strobe;
    logic       err;
    int         stalls;
    for (int i = 0; i < TXBUF_WORDS; i++) begin
        full   = next_random();
        part   = next_random();
        strobe = 4'(next_random());
        write_word(tx_word_addr(32 + 3 * i), full, 4'hF, err);
        check("bus_error", 32'(err), 32'h0);
        write_word(tx_word_addr(32 + 3 * i), part, strobe, err);
        check("bus_error", 32'(err), 32'h0);
        expected[i] = merge_bytes(full, part, strobe);
    end
    for (int i = 0; i < TXBUF_WORDS; i++) begin
        read_word(tx_word_addr(32 + 3 * i), rdata, stalls);
        check("bus_rdata", rdata, expected[i]);
        check("bus_request_stall cycles", 32'(stalls), 32'h0);
    end
    read_word(32'h0000_4000, rdata, stalls);
    check("bus_rdata", rdata, endpoint_pkg::BAD_DATA);
endtask

// writes a header of length len at word base with its payload after it and points slot at it.
task automatic store_message(input int slot, input int base, input int len);
    word_t w;
    logic  err;
    msg_words.delete();
    for (int k = 0; k <= len; k++) begin
        w = next_random();
        if (k == 0) begin
            w[LEN_BITS-1:0] = LEN_BITS'(len);
        end
        msg_words.push_back(w);
        write_word(tx_word_addr(base + k), w, 4'hF, err);
        check("bus_error", 32'(err), 32'h0);
    end
    write_word(endpoint_pkg::START_TABLE_BASE + 32'(4 * slot), tx_word_addr(base), 4'hF, err);
    check("bus_error", 32'(err), 32'h0);
endtask

task automatic message_send();
    logic err;
    store_message(2, MSG_BASE, MSG_LEN);
    write_word(endpoint_pkg::TX_SEND_ADDR, 32'd2, 4'hF, err);
    check("bus_error", 32'(err), 32'h0);
    // one cycle after the send the header is still being read.
    check("flit_out_valid", 32'(flit_out_valid), 32'h0);
    for (int k = 0; k <= MSG_LEN; k++) begin
        @(negedge clk);
        check("flit_out_valid", 32'(flit_out_valid), 32'h1);
        check("flit_out.data", flit_out.data, msg_words[k]);
        check("flit_out.last", 32'(flit_out.last), 32'(k == MSG_LEN));
    end
    @(negedge clk);
    check("flit_out_valid", 32'(flit_out_valid), 32'h0);
endtask

task automatic busy_contention();
    word_t spare;
    word_t spare_addr;
    word_t rdata;
    logic  err;
    int    stalls;
    store_message(1, BUSY_BASE, BUSY_LEN);
    write_word(endpoint_pkg::TX_SEND_ADDR, 32'd1, 4'hF, err);
    check("bus_error", 32'(err), 32'h0);
    write_word(endpoint_pkg::TX_SEND_ADDR, 32'd1, 4'hF, err);
    check("bus_error", 32'(err), 32'h1);
    // held off until the engine lets go of the buffer.
    spare      = next_random();
    spare_addr = tx_word_addr(BUSY_BASE + BUSY_LEN + 1);
    bus_access(1'b1, spare_addr, spare, 4'hF, rdata, err, stalls);
    check("bus_error", 32'(err), 32'h0);
    check("bus_request_stall seen", 32'(stalls > 0), 32'h1);
    // the message words stay as stored.
    for (int k = 0; k <= BUSY_LEN; k++) begin
        read_word(tx_word_addr(BUSY_BASE + k), rdata, stalls);
        check("bus_rdata", rdata, msg_words[k]);
        check("bus_request_stall cycles", 32'(stalls), 32'h0);
    end
    read_word(spare_addr, rdata, stalls);
    check("bus_rdata", rdata, spare);
endtask

task automatic receive_stream();
    word_t sent [RX_FLITS];
    word_t rdata;
    logic  err;
    int    stalls;
    for (int i = 0; i < RX_FLITS; i++) begin
        sent[i] = next_random();
        drive_flit(sent[i], i == RX_FLITS - 1, (i % 3 == 1) ? MAX_GAP : 0);
    end
    for (int i = 0; i < RX_FLITS; i++) begin
        read_word(endpoint_pkg::RX_BUF_BASE + 32'(4 * i), rdata, stalls);
        check("bus_rdata", rdata, sent[i]);
    end
    read_word(endpoint_pkg::RX_COUNT_ADDR, rdata, stalls);
    check("rx_count", rdata, 32'(RX_FLITS));
    write_word(endpoint_pkg::RX_BUF_BASE, ~sent[0], 4'hF, err);
    check("bus_error", 32'(err), 32'h1);
    read_word(endpoint_pkg::RX_BUF_BASE, rdata, stalls);
    check("bus_rdata", rdata, sent[0]);
endtask

// ==== testbench/tb_chiplet_endpoint.sv ====
`timescale 1ns/100ps

module tb_chiplet_endpoint;

    typedef endpoint_pkg::word_t word_t;

    localparam int NUM_MSGS     = 4;
    localparam int NUM_WORDS    = 128;
    localparam int LEN_BITS     = endpoint_pkg::HDR_LEN_BITS;
    localparam int CLK_PERIOD   = 10;
    localparam int SETTLE       = 1;
    localparam int RESET_CYCLES = 3;
    localparam int STALL_LIMIT  = 200;

    // test sizes, the watchdog limit follows from them.
    localparam int TXBUF_WORDS = 8;
    localparam int MSG_BASE    = NUM_WORDS - 2;
    localparam int MSG_LEN     = 6;
    localparam int BUSY_BASE   = 80;
    localparam int BUSY_LEN    = 20;
    localparam int RX_FLITS    = 12;
    localparam int MAX_GAP     = 2;
    localparam int TEST_CYCLES = (2 * NUM_MSGS + 3) + (3 * TXBUF_WORDS + 1) +
                                 (3 * MSG_LEN + 8) + (4 * BUSY_LEN + 10) +
                                 (RX_FLITS * (2 + MAX_GAP) + 4);
    localparam int WATCHDOG_NS = 2 * (TEST_CYCLES + RESET_CYCLES + 2) * CLK_PERIOD;

    logic                clk;
    logic                n_rst;
    logic                data_ready;
    endpoint_pkg::flit_t flit_in;
    endpoint_pkg::flit_t flit_out;
    logic                flit_out_valid;
    logic                bus_wen;
    logic                bus_ren;
    word_t               bus_addr;
    word_t               bus_wdata;
    logic [3:0]          bus_strobe;
    word_t               bus_rdata;
    logic                bus_error;
    logic                bus_request_stall;

    word_t rng_state = 32'h6b00_0cd0;
    word_t msg_words [$];

    chiplet_endpoint #(.NUM_MSGS(NUM_MSGS), .NUM_WORDS(NUM_WORDS)) dut_i (
        .clk, .n_rst, .data_ready, .flit_in, .flit_out, .flit_out_valid,
        .bus_wen, .bus_ren, .bus_addr, .bus_wdata, .bus_strobe,
        .bus_rdata, .bus_error, .bus_request_stall
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            abort_run();
        end
    endtask

    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input logic [3:0] strobe);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // byte address of a transmit buffer word, wrapping at the depth.
    function automatic word_t tx_word_addr(input int idx);
        return endpoint_pkg::TX_BUF_BASE + 32'(4 * (idx % NUM_WORDS));
    endfunction

    ////////////////////////////////////////
    // drivers
    ////////////////////////////////////////

    // called at a falling edge, returns at the falling edge after the access.
    task automatic bus_access(input logic write, input word_t addr, input word_t wdata,
                              input logic [3:0] strobe, output word_t rdata,
                              output logic err, output int stalls);
        stalls     = 0;
        bus_wen    = write;
        bus_ren    = !write;
        bus_addr   = addr;
        bus_wdata  = wdata;
        bus_strobe = strobe;
        #SETTLE;
        while (bus_request_stall) begin
            stalls++;
            if (stalls > STALL_LIMIT) begin
                $display("bus access to %h stayed stalled for %0d cycles", addr, stalls);
                abort_run();
            end
            @(negedge clk);
            #SETTLE;
        end
        rdata = bus_rdata;
        err   = bus_error;
        @(negedge clk);
        bus_wen = 1'b0;
        bus_ren = 1'b0;
    endtask

    task automatic write_word(input word_t addr, input word_t data, input logic [3:0] strobe,
                              output logic err);
        word_t rdata;
        int    stalls;
        bus_access(1'b1, addr, data, strobe, rdata, err, stalls);
    endtask

    task automatic read_word(input word_t addr, output word_t data, output int stalls);
        logic err;
        bus_access(1'b0, addr, '0, 4'h0, data, err, stalls);
        check("bus_error", 32'(err), 32'h0);
    endtask

    task automatic drive_flit(input word_t data, input logic last, input int gap);
        data_ready   = 1'b1;
        flit_in.data = data;
        flit_in.last = last;
        @(negedge clk);
        data_ready = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    `include "endpoint_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        clk        = 1'b0;
        n_rst      = 1'b0;
        data_ready = 1'b0;
        flit_in    = '0;
        bus_wen    = 1'b0;
        bus_ren    = 1'b0;
        bus_addr   = '0;
        bus_wdata  = '0;
        bus_strobe = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        #SETTLE;
        check("flit_out_valid", 32'(flit_out_valid), 32'h0);
        check("bus_error", 32'(bus_error), 32'h0);
        check("bus_request_stall", 32'(bus_request_stall), 32'h0);
        @(negedge clk);
        start_table_readback();
        tx_buffer_strobes();
        message_send();
        busy_contention();
        receive_stream();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== chiplet_endpoint.f ====
+incdir+testbench
design/endpoint_pkg.sv
design/mem_bus_if.sv
design/word_buffer.sv
design/tx_engine.sv
design/rx_assembler.sv
design/endpoint_decoder.sv
design/chiplet_endpoint.sv
testbench/tb_chiplet_endpoint.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_chiplet_endpoint
FILELIST  := chiplet_endpoint.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the exit code of the pipe.
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
